// ==== verilog/tile_mem_settings.svh ====
// ----------------------------------------------------------------------
// Widths, lane count, walker command code, refill beat and requester ids
// ----------------------------------------------------------------------

`ifndef TILE_MEM_SETTINGS_SVH
`define TILE_MEM_SETTINGS_SVH

// Memory request line
`define DMEM_ADDR_W      40
`define DMEM_WORD_W      64
`define DMEM_WORDS       2

// Walker and refill encodings
`define PTW_CMD_AMO_OR   5'b01010
`define REFILL_LAST_BEAT 3
`define EVT_CNT_W        16

// Requester ids on the memory port
`define DMEM_TID_PTW     0
`define DMEM_TID_CORE    1

`endif

// ==== verilog/tile_mem_pkg.sv ====
// ----------------------------------------------------------------------
// Vector types and memory operation encoding for the tile memory glue
// ----------------------------------------------------------------------

`include "tile_mem_settings.svh"

package tile_mem_pkg;

    // Address and data
    typedef logic [`DMEM_ADDR_W-1:0]                 dmem_addr_t;
    typedef logic [`DMEM_WORD_W-1:0]                 dmem_word_t;
    typedef logic [`DMEM_WORDS*`DMEM_WORD_W-1:0]     dmem_line_t;
    typedef logic [`DMEM_WORDS*`DMEM_WORD_W/8-1:0]   dmem_be_t;

    // Request attributes
    typedef logic [2:0]                              dmem_size_t;
    typedef logic [0:0]                              dmem_tid_t;
    typedef logic [4:0]                              ptw_cmd_t;

    // Instruction refill and event counting
    typedef logic [1:0]                              refill_beat_t;
    typedef logic [`EVT_CNT_W-1:0]                   evt_cnt_t;

    // Operation on the memory port
    typedef enum logic [1:0] {
        DMEM_LOAD   = 2'd0,
        DMEM_STORE  = 2'd1,
        DMEM_AMO_OR = 2'd2
    } dmem_op_e;

endpackage

// ==== verilog/dmem_req_if.sv ====
// ----------------------------------------------------------------------
// Line-format memory request with valid/ready handshake
// ----------------------------------------------------------------------

interface dmem_req_if;
    import tile_mem_pkg::*;

    logic       valid;
    logic       ready;
    dmem_addr_t addr;
    dmem_op_e   op;
    dmem_size_t size;
    dmem_line_t wdata;
    dmem_be_t   be;
    dmem_tid_t  tid;

    // Requester side
    modport src (
        output valid, addr, op, size, wdata, be, tid,
        input  ready
    );

    // Arbiter side
    modport dst (
        input  valid, addr, op, size, wdata, be, tid,
        output ready
    );

endinterface

// ==== verilog/ptw_req_packer.sv ====
// ----------------------------------------------------------------------
// Walker request packing into a two-word line request
// ----------------------------------------------------------------------

`include "tile_mem_settings.svh"

module ptw_req_packer (
    input  logic                      ptw_req_valid_i,
    output logic                      ptw_req_ready_o,
    input  tile_mem_pkg::dmem_addr_t  ptw_req_addr_i,
    input  tile_mem_pkg::ptw_cmd_t    ptw_req_cmd_i,
    input  tile_mem_pkg::dmem_size_t  ptw_req_typ_i,
    input  tile_mem_pkg::dmem_word_t  ptw_req_data_i,
    dmem_req_if.src                   req
);
    import tile_mem_pkg::*;

    localparam int LANE_W = $clog2(`DMEM_WORDS);
    localparam int BE_W   = `DMEM_WORD_W / 8;

    logic [LANE_W-1:0] lane;
    logic              is_amo;

    // Lane from the word offset, bit 3 upwards
    assign lane   = ptw_req_addr_i[LANE_W+2:3];
    assign is_amo = (ptw_req_cmd_i == `PTW_CMD_AMO_OR);

    assign req.valid = ptw_req_valid_i;
    assign req.addr  = ptw_req_addr_i;
    assign req.op    = is_amo ? DMEM_AMO_OR : DMEM_LOAD;
    assign req.size  = ptw_req_typ_i;
    assign req.tid   = dmem_tid_t'(`DMEM_TID_PTW);

    // Data and byte enables only in the selected lane
    always_comb begin
        req.wdata = '0;
        req.be    = '0;
        req.wdata[lane*`DMEM_WORD_W +: `DMEM_WORD_W] = ptw_req_data_i;
        if (is_amo) begin
            req.be[lane*BE_W +: BE_W] = '1;
        end
    end

    assign ptw_req_ready_o = req.ready;

    // Loads from the walker never write any byte
    be_only_amo_a: assert final (req.be == '0 || ptw_req_cmd_i == `PTW_CMD_AMO_OR)
        else $error("walker byte enables set on a non AMO-OR request");

endmodule

// ==== verilog/ptw_rdata_picker.sv ====
// ----------------------------------------------------------------------
// Walker word offset capture and response word selection
// ----------------------------------------------------------------------

`include "tile_mem_settings.svh"

module ptw_rdata_picker (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      accept_i,
    input  tile_mem_pkg::dmem_addr_t  addr_i,
    input  tile_mem_pkg::dmem_line_t  rdata_i,
    output tile_mem_pkg::dmem_word_t  word_o
);

    localparam int LANE_W = $clog2(`DMEM_WORDS);

    logic [LANE_W-1:0] offset_q;

    // Offset of the accepted request, kept until the next walker transfer
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            offset_q <= '0;
        end else if (accept_i) begin
            offset_q <= addr_i[LANE_W+2:3];
        end
    end

    // Core traffic in flight does not disturb the captured offset
    assign word_o = rdata_i[offset_q*`DMEM_WORD_W +: `DMEM_WORD_W];

endmodule

// ==== verilog/dmem_port_ctrl.sv ====
// ----------------------------------------------------------------------
// Memory port arbiter: grant, outstanding tracking, response routing
// ----------------------------------------------------------------------

`include "tile_mem_settings.svh"

module dmem_port_ctrl (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    dmem_req_if.dst                   ptw,
    input  logic                      core_req_valid_i,
    output logic                      core_req_ready_o,
    input  tile_mem_pkg::dmem_addr_t  core_req_addr_i,
    input  tile_mem_pkg::dmem_op_e    core_req_op_i,
    input  tile_mem_pkg::dmem_size_t  core_req_size_i,
    input  tile_mem_pkg::dmem_line_t  core_req_wdata_i,
    input  tile_mem_pkg::dmem_be_t    core_req_be_i,
    output logic                      dmem_req_valid_o,
    input  logic                      dmem_req_ready_i,
    output tile_mem_pkg::dmem_addr_t  dmem_req_addr_o,
    output tile_mem_pkg::dmem_op_e    dmem_req_op_o,
    output tile_mem_pkg::dmem_size_t  dmem_req_size_o,
    output tile_mem_pkg::dmem_line_t  dmem_req_wdata_o,
    output tile_mem_pkg::dmem_be_t    dmem_req_be_o,
    output tile_mem_pkg::dmem_tid_t   dmem_req_tid_o,
    input  logic                      dmem_rsp_valid_i,
    input  tile_mem_pkg::dmem_tid_t   dmem_rsp_tid_i,
    output logic                      ptw_rsp_valid_o,
    output logic                      core_rsp_valid_o,
    output logic                      ptw_accept_o
);
    import tile_mem_pkg::*;

    logic ptw_outst_q;
    logic core_outst_q;
    logic lock_q;
    logic lock_core_q;
    logic gnt_ptw;
    logic gnt_core;
    logic ptw_xfer;
    logic core_xfer;
    logic rsp_is_ptw;

    // ------------------------------------------------------------------
    // Grant
    // ------------------------------------------------------------------

    // Walker first; a held request keeps the port until it transfers
    always_comb begin
        if (lock_q) begin
            gnt_ptw  = !lock_core_q;
            gnt_core = lock_core_q;
        end else begin
            gnt_ptw  = ptw.valid && !ptw_outst_q;
            gnt_core = !gnt_ptw && core_req_valid_i && !core_outst_q;
        end
    end

    assign ptw.ready        = dmem_req_ready_i && gnt_ptw;
    assign core_req_ready_o = dmem_req_ready_i && gnt_core;

    assign ptw_xfer     = ptw.valid && ptw.ready;
    assign core_xfer    = core_req_valid_i && core_req_ready_o;
    assign ptw_accept_o = ptw_xfer;

    // ------------------------------------------------------------------
    // Request mux
    // ------------------------------------------------------------------

    assign dmem_req_valid_o = (gnt_ptw && ptw.valid) || (gnt_core && core_req_valid_i);
    assign dmem_req_addr_o  = gnt_core ? core_req_addr_i  : ptw.addr;
    assign dmem_req_op_o    = gnt_core ? core_req_op_i    : ptw.op;
    assign dmem_req_size_o  = gnt_core ? core_req_size_i  : ptw.size;
    assign dmem_req_wdata_o = gnt_core ? core_req_wdata_i : ptw.wdata;
    assign dmem_req_be_o    = gnt_core ? core_req_be_i    : ptw.be;
    assign dmem_req_tid_o   = gnt_core ? dmem_tid_t'(`DMEM_TID_CORE) : ptw.tid;

    // ------------------------------------------------------------------
    // Responses and outstanding flags
    // ------------------------------------------------------------------

    assign rsp_is_ptw       = (dmem_rsp_tid_i == dmem_tid_t'(`DMEM_TID_PTW));
    assign ptw_rsp_valid_o  = dmem_rsp_valid_i && rsp_is_ptw;
    assign core_rsp_valid_o = dmem_rsp_valid_i && !rsp_is_ptw;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ptw_outst_q  <= 1'b0;
            core_outst_q <= 1'b0;
            lock_q       <= 1'b0;
            lock_core_q  <= 1'b0;
        end else begin
            ptw_outst_q  <= (ptw_outst_q && !ptw_rsp_valid_o) || ptw_xfer;
            core_outst_q <= (core_outst_q && !core_rsp_valid_o) || core_xfer;
            // Stalled by memory
            lock_q       <= dmem_req_valid_o && !dmem_req_ready_i;
            lock_core_q  <= gnt_core;
        end
    end

    rsp_has_owner_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        dmem_rsp_valid_i |-> (rsp_is_ptw ? ptw_outst_q : core_outst_q))
        else $error("memory response without an outstanding request");

    req_stable_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        dmem_req_valid_o && !dmem_req_ready_i |=> dmem_req_valid_o &&
        $stable({dmem_req_addr_o, dmem_req_op_o, dmem_req_size_o,
                 dmem_req_wdata_o, dmem_req_be_o, dmem_req_tid_o}))
        else $error("memory request changed while stalled");

endmodule

// ==== verilog/refill_event_counter.sv ====
// ----------------------------------------------------------------------
// Refill acknowledge decode and saturating refill event counters
// ----------------------------------------------------------------------

`include "tile_mem_settings.svh"

module refill_event_counter (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        grant_valid_i,
    input  tile_mem_pkg::refill_beat_t  grant_beat_i,
    input  logic                        l2_hit_i,
    output tile_mem_pkg::evt_cnt_t      refill_count_o,
    output tile_mem_pkg::evt_cnt_t      refill_l2_hit_count_o
);
    import tile_mem_pkg::*;

    logic refill_ack;

    // Holds at all ones
    function automatic evt_cnt_t sat_inc(evt_cnt_t cnt, logic en);
        if (en && cnt != '1) begin
            return cnt + 1'b1;
        end
        return cnt;
    endfunction

    // Last beat of a grant closes the refill
    assign refill_ack = grant_valid_i &&
                        (grant_beat_i == refill_beat_t'(`REFILL_LAST_BEAT));

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            refill_count_o        <= '0;
            refill_l2_hit_count_o <= '0;
        end else begin
            refill_count_o        <= sat_inc(refill_count_o, refill_ack);
            refill_l2_hit_count_o <= sat_inc(refill_l2_hit_count_o, refill_ack && l2_hit_i);
        end
    end

endmodule

// ==== verilog/tile_mem_glue.sv ====
// ----------------------------------------------------------------------
// Tile memory glue: walker and core onto one data memory port,
// plus instruction refill event counters
// ----------------------------------------------------------------------

module tile_mem_glue (
    input  logic                        clk_i,
    input  logic                        rst_n_i,

    // Page-table walker
    input  logic                        ptw_req_valid_i,
    output logic                        ptw_req_ready_o,
    input  tile_mem_pkg::dmem_addr_t    ptw_req_addr_i,
    input  tile_mem_pkg::ptw_cmd_t      ptw_req_cmd_i,
    input  tile_mem_pkg::dmem_size_t    ptw_req_typ_i,
    input  tile_mem_pkg::dmem_word_t    ptw_req_data_i,
    output logic                        ptw_rsp_valid_o,
    output tile_mem_pkg::dmem_word_t    ptw_rsp_data_o,

    // Core, already in line format
    input  logic                        core_req_valid_i,
    output logic                        core_req_ready_o,
    input  tile_mem_pkg::dmem_addr_t    core_req_addr_i,
    input  tile_mem_pkg::dmem_op_e      core_req_op_i,
    input  tile_mem_pkg::dmem_size_t    core_req_size_i,
    input  tile_mem_pkg::dmem_line_t    core_req_wdata_i,
    input  tile_mem_pkg::dmem_be_t      core_req_be_i,
    output logic                        core_rsp_valid_o,
    output tile_mem_pkg::dmem_line_t    core_rsp_rdata_o,

    // Data memory port
    output logic                        dmem_req_valid_o,
    input  logic                        dmem_req_ready_i,
    output tile_mem_pkg::dmem_addr_t    dmem_req_addr_o,
    output tile_mem_pkg::dmem_op_e      dmem_req_op_o,
    output tile_mem_pkg::dmem_size_t    dmem_req_size_o,
    output tile_mem_pkg::dmem_line_t    dmem_req_wdata_o,
    output tile_mem_pkg::dmem_be_t      dmem_req_be_o,
    output tile_mem_pkg::dmem_tid_t     dmem_req_tid_o,
    input  logic                        dmem_rsp_valid_i,
    input  tile_mem_pkg::dmem_tid_t     dmem_rsp_tid_i,
    input  tile_mem_pkg::dmem_line_t    dmem_rsp_rdata_i,

    // Instruction refill grant from L2
    input  logic                        grant_valid_i,
    input  tile_mem_pkg::refill_beat_t  grant_beat_i,
    input  logic                        l2_hit_i,
    output tile_mem_pkg::evt_cnt_t      refill_count_o,
    output tile_mem_pkg::evt_cnt_t      refill_l2_hit_count_o
);

    logic ptw_accept;

    dmem_req_if ptw_req_if ();

    ptw_req_packer ptw_req_packer_i (
        .ptw_req_valid_i ( ptw_req_valid_i ),
        .ptw_req_ready_o ( ptw_req_ready_o ),
        .ptw_req_addr_i  ( ptw_req_addr_i  ),
        .ptw_req_cmd_i   ( ptw_req_cmd_i   ),
        .ptw_req_typ_i   ( ptw_req_typ_i   ),
        .ptw_req_data_i  ( ptw_req_data_i  ),
        .req             ( ptw_req_if.src  )
    );

    // Walker word from the returned line
    ptw_rdata_picker ptw_rdata_picker_i (
        .clk_i    ( clk_i            ),
        .rst_n_i  ( rst_n_i          ),
        .accept_i ( ptw_accept       ),
        .addr_i   ( ptw_req_addr_i   ),
        .rdata_i  ( dmem_rsp_rdata_i ),
        .word_o   ( ptw_rsp_data_o   )
    );

    dmem_port_ctrl dmem_port_ctrl_i (
        .clk_i            ( clk_i            ),
        .rst_n_i          ( rst_n_i          ),
        .ptw              ( ptw_req_if.dst   ),
        .core_req_valid_i ( core_req_valid_i ),
        .core_req_ready_o ( core_req_ready_o ),
        .core_req_addr_i  ( core_req_addr_i  ),
        .core_req_op_i    ( core_req_op_i    ),
        .core_req_size_i  ( core_req_size_i  ),
        .core_req_wdata_i ( core_req_wdata_i ),
        .core_req_be_i    ( core_req_be_i    ),
        .dmem_req_valid_o ( dmem_req_valid_o ),
        .dmem_req_ready_i ( dmem_req_ready_i ),
        .dmem_req_addr_o  ( dmem_req_addr_o  ),
        .dmem_req_op_o    ( dmem_req_op_o    ),
        .dmem_req_size_o  ( dmem_req_size_o  ),
        .dmem_req_wdata_o ( dmem_req_wdata_o ),
        .dmem_req_be_o    ( dmem_req_be_o    ),
        .dmem_req_tid_o   ( dmem_req_tid_o   ),
        .dmem_rsp_valid_i ( dmem_rsp_valid_i ),
        .dmem_rsp_tid_i   ( dmem_rsp_tid_i   ),
        .ptw_rsp_valid_o  ( ptw_rsp_valid_o  ),
        .core_rsp_valid_o ( core_rsp_valid_o ),
        .ptw_accept_o     ( ptw_accept       )
    );

    // Core takes the whole line
    assign core_rsp_rdata_o = dmem_rsp_rdata_i;

    refill_event_counter refill_event_counter_i (
        .clk_i                 ( clk_i                 ),
        .rst_n_i               ( rst_n_i               ),
        .grant_valid_i         ( grant_valid_i         ),
        .grant_beat_i          ( grant_beat_i          ),
        .l2_hit_i              ( l2_hit_i              ),
        .refill_count_o        ( refill_count_o        ),
        .refill_l2_hit_count_o ( refill_l2_hit_count_o )
    );

endmodule

// ==== sim/tb_tile_mem_glue.sv ====
// ----------------------------------------------------------------------
// Testbench for tile_mem_glue with request table, memory model and refill counts
// ----------------------------------------------------------------------

`include "tile_mem_settings.svh"

module tb_tile_mem_glue;
    timeunit 1ns;
    timeprecision 1ps;
    import tile_mem_pkg::*;

    localparam int             TIMEOUT     = 100;
    localparam logic [4:0]     HIT_PATTERN = 5'b01101;

    // Walker rows carry the walker word in the low data word and expected op and be
    // Core rows drive data, op and be and expect them unchanged
    typedef struct packed {
        logic       is_core;
        dmem_addr_t addr;
        ptw_cmd_t   cmd;
        dmem_op_e   op;
        dmem_size_t size;
        dmem_line_t data;
        dmem_be_t   be;
        dmem_line_t rsp;
        dmem_line_t exp_wdata;
        dmem_line_t exp_rsp;
    } row_t;

    logic         clk_i;
    logic         rst_n_i;
    logic         ptw_req_valid_i;
    logic         ptw_req_ready_o;
    dmem_addr_t   ptw_req_addr_i;
    ptw_cmd_t     ptw_req_cmd_i;
    dmem_size_t   ptw_req_typ_i;
    dmem_word_t   ptw_req_data_i;
    logic         ptw_rsp_valid_o;
    dmem_word_t   ptw_rsp_data_o;
    logic         core_req_valid_i;
    logic         core_req_ready_o;
    dmem_addr_t   core_req_addr_i;
    dmem_op_e     core_req_op_i;
    dmem_size_t   core_req_size_i;
    dmem_line_t   core_req_wdata_i;
    dmem_be_t     core_req_be_i;
    logic         core_rsp_valid_o;
    dmem_line_t   core_rsp_rdata_o;
    logic         dmem_req_valid_o;
    logic         dmem_req_ready_i = 1'b0;
    dmem_addr_t   dmem_req_addr_o;
    dmem_op_e     dmem_req_op_o;
    dmem_size_t   dmem_req_size_o;
    dmem_line_t   dmem_req_wdata_o;
    dmem_be_t     dmem_req_be_o;
    dmem_tid_t    dmem_req_tid_o;
    logic         dmem_rsp_valid_i = 1'b0;
    dmem_tid_t    dmem_rsp_tid_i = '0;
    dmem_line_t   dmem_rsp_rdata_i = '0;
    logic         grant_valid_i;
    refill_beat_t grant_beat_i;
    logic         l2_hit_i;
    evt_cnt_t     refill_count_o;
    evt_cnt_t     refill_l2_hit_count_o;

    row_t         rows [6];
    dmem_line_t   rsp_line [2];
    logic         hold_rsp = 1'b0;
    int           err_cnt = 0;
    int           tests_run = 0;
    int           tests_failed = 0;

    tile_mem_glue tile_mem_glue_i (.*);

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    // ------------------------------------------------------------------
    // Memory model with random ready, answering the newest request first
    // ------------------------------------------------------------------
    initial begin
        dmem_tid_t pend_q [$];
        dmem_tid_t tid;
        int        wait_cnt;
        wait_cnt = 0;
        void'($urandom(32'h7a5ff736));
        forever begin
            @(posedge clk_i);
            dmem_rsp_valid_i <= 1'b0;
            if (!rst_n_i) begin
                pend_q.delete();
                dmem_req_ready_i <= 1'b0;
            end else begin
                dmem_req_ready_i <= ($urandom % 4) != 0;
                if (dmem_req_valid_o && dmem_req_ready_i) begin
                    pend_q.push_back(dmem_req_tid_o);
                    wait_cnt = 2 + $urandom % 4;
                end else if (pend_q.size() != 0 && !hold_rsp) begin
                    if (wait_cnt > 0) begin
                        wait_cnt--;
                    end else begin
                        tid = pend_q.pop_back();
                        dmem_rsp_valid_i <= 1'b1;
                        dmem_rsp_tid_i   <= tid;
                        dmem_rsp_rdata_i <= rsp_line[tid];
                        wait_cnt = 1 + $urandom % 3;
                    end
                end
            end
        end
    end

    // ------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------
    task automatic check_val(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
        if (got !== exp) begin
            $display("Error: %s = %h, expected %h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic report_test(input string name, input int errs0);
        tests_run++;
        if (err_cnt != errs0) begin
            tests_failed++;
            $display("Test %-24s FAIL (%0d errors)", name, err_cnt - errs0);
        end else begin
            $display("Test %-24s ok", name);
        end
    endtask

    task automatic drive_row(input row_t r);
        if (r.is_core) begin
            core_req_valid_i <= 1'b1;
            core_req_addr_i  <= r.addr;
            core_req_op_i    <= r.op;
            core_req_size_i  <= r.size;
            core_req_wdata_i <= r.data;
            core_req_be_i    <= r.be;
        end else begin
            ptw_req_valid_i <= 1'b1;
            ptw_req_addr_i  <= r.addr;
            ptw_req_cmd_i   <= r.cmd;
            ptw_req_typ_i   <= r.size;
            ptw_req_data_i  <= r.data[63:0];
        end
    endtask

    // Returns at the edge where the memory port transfers
    task automatic wait_mem_xfer(output bit ok);
        ok = 1'b0;
        for (int i = 0; i < TIMEOUT && !ok; i++) begin
            @(posedge clk_i);
            ok = dmem_req_valid_o && dmem_req_ready_i;
        end
        if (!ok) begin
            $display("Timeout: no transfer on the memory request port");
            err_cnt++;
        end
    endtask

    task automatic wait_rsp(output bit rsp_core, output bit ok);
        ok = 1'b0;
        rsp_core = 1'b0;
        for (int i = 0; i < TIMEOUT && !ok; i++) begin
            @(posedge clk_i);
            ok = ptw_rsp_valid_o || core_rsp_valid_o;
            rsp_core = core_rsp_valid_o;
        end
        if (!ok) begin
            $display("Timeout: no response reached the walker or the core");
            err_cnt++;
        end
    endtask

    task automatic check_fields(input row_t r);
        // Only the granted requester sees ready on the transfer
        check_val("ptw_req_ready_o", ptw_req_ready_o, !r.is_core);
        check_val("core_req_ready_o", core_req_ready_o, r.is_core);
        check_val("dmem_req_addr_o", dmem_req_addr_o, r.addr);
        check_val("dmem_req_op_o", dmem_req_op_o, r.op);
        check_val("dmem_req_size_o", dmem_req_size_o, r.size);
        check_val("dmem_req_wdata_o", dmem_req_wdata_o, r.exp_wdata);
        check_val("dmem_req_be_o", dmem_req_be_o, r.be);
        check_val("dmem_req_tid_o", dmem_req_tid_o,
                  r.is_core ? `DMEM_TID_CORE : `DMEM_TID_PTW);
    endtask

    task automatic check_rsp(input row_t r, input bit rsp_core);
        check_val("core_rsp_valid_o", rsp_core, r.is_core);
        check_val("ptw_rsp_valid_o", ptw_rsp_valid_o, !r.is_core);
        if (r.is_core) begin
            check_val("core_rsp_rdata_o", core_rsp_rdata_o, r.exp_rsp);
        end else begin
            check_val("ptw_rsp_data_o", ptw_rsp_data_o, r.exp_rsp);
        end
    endtask

    // ------------------------------------------------------------------
    // Tests
    // ------------------------------------------------------------------
    task automatic run_row(input string name, input int idx);
        row_t r;
        bit   ok;
        bit   rsp_core;
        int   errs0;
        r = rows[idx];
        errs0 = err_cnt;
        rsp_line[r.is_core] <= r.rsp;
        @(posedge clk_i);
        drive_row(r);
        wait_mem_xfer(ok);
        if (ok) begin
            check_fields(r);
        end
        ptw_req_valid_i  <= 1'b0;
        core_req_valid_i <= 1'b0;
        wait_rsp(rsp_core, ok);
        if (ok) begin
            check_rsp(r, rsp_core);
        end
        report_test(name, errs0);
    endtask

    // Walker and core at once with answers held back and returned LIFO
    task automatic dual_test();
        bit ok;
        bit rsp_core;
        int errs0;
        errs0 = err_cnt;
        hold_rsp    <= 1'b1;
        rsp_line[0] <= rows[1].rsp;
        rsp_line[1] <= rows[4].rsp;
        @(posedge clk_i);
        drive_row(rows[1]);
        drive_row(rows[4]);
        wait_mem_xfer(ok);
        if (ok) begin
            check_fields(rows[1]);
        end
        // Second walker request while the first is outstanding
        drive_row(rows[2]);
        wait_mem_xfer(ok);
        if (ok) begin
            check_fields(rows[4]);
        end
        core_req_valid_i <= 1'b0;
        repeat (6) begin
            @(posedge clk_i);
            check_val("ptw_req_ready_o", ptw_req_ready_o, 1'b0);
        end
        hold_rsp <= 1'b0;
        wait_rsp(rsp_core, ok);
        if (ok) begin
            check_rsp(rows[4], rsp_core);
        end
        wait_rsp(rsp_core, ok);
        if (ok) begin
            check_rsp(rows[1], rsp_core);
        end
        rsp_line[0] <= rows[2].rsp;
        wait_mem_xfer(ok);
        if (ok) begin
            check_fields(rows[2]);
        end
        ptw_req_valid_i <= 1'b0;
        wait_rsp(rsp_core, ok);
        if (ok) begin
            check_rsp(rows[2], rsp_core);
        end
        report_test("walker and core together", errs0);
    endtask

    task automatic refill_test();
        int   exp_refill;
        int   exp_hit;
        int   errs0;
        logic hit;
        exp_refill = 0;
        exp_hit = 0;
        errs0 = err_cnt;
        for (int k = 0; k < 5; k++) begin
            for (int b = 0; b < 4; b++) begin
                // l2_hit_i high on early beats must not count
                hit = (b == `REFILL_LAST_BEAT) ? HIT_PATTERN[k] : 1'b1;
                @(posedge clk_i);
                grant_valid_i <= 1'b1;
                grant_beat_i  <= b[1:0];
                l2_hit_i      <= hit;
                @(posedge clk_i);
                grant_valid_i <= 1'b0;
                l2_hit_i      <= 1'b0;
                if (b == `REFILL_LAST_BEAT) begin
                    exp_refill++;
                    exp_hit += hit;
                end
                @(posedge clk_i);
                check_val("refill_count_o", refill_count_o, exp_refill);
                check_val("refill_l2_hit_count_o", refill_l2_hit_count_o, exp_hit);
            end
        end
        report_test("refill counters", errs0);
    endtask

    task automatic load_table();
        rows[0] = '{1'b0, 40'h00_8000_1000, 5'h00, DMEM_LOAD, 3'd3,
                    {64'h0, 64'h0000_0000_8000_1001}, 16'h0000,
                    {64'hc0de_0001_0000_00a1, 64'hc0de_0000_0000_00a0},
                    {64'h0, 64'h0000_0000_8000_1001}, {64'h0, 64'hc0de_0000_0000_00a0}};
        rows[1] = '{1'b0, 40'h00_8000_1008, 5'h01, DMEM_LOAD, 3'd3,
                    {64'h0, 64'h0000_0000_8000_2002}, 16'h0000,
                    {64'hc0de_0011_0000_00b1, 64'hc0de_0010_0000_00b0},
                    {64'h0000_0000_8000_2002, 64'h0}, {64'h0, 64'hc0de_0011_0000_00b1}};
        rows[2] = '{1'b0, 40'h00_8000_2008, 5'b01010, DMEM_AMO_OR, 3'd3,
                    {64'h0, 64'h0000_0000_0000_00c0}, 16'hff00,
                    {64'hc0de_0021_0000_00d1, 64'hc0de_0020_0000_00d0},
                    {64'h0000_0000_0000_00c0, 64'h0}, {64'h0, 64'hc0de_0021_0000_00d1}};
        rows[3] = '{1'b0, 40'h00_8000_3010, 5'b01010, DMEM_AMO_OR, 3'd3,
                    {64'h0, 64'h0000_0000_0000_0040}, 16'h00ff,
                    {64'hc0de_0031_0000_00e1, 64'hc0de_0030_0000_00e0},
                    {64'h0, 64'h0000_0000_0000_0040}, {64'h0, 64'hc0de_0030_0000_00e0}};
        rows[4] = '{1'b1, 40'h00_9000_0040, 5'h00, DMEM_STORE, 3'd4,
                    {64'h1234_5678_9abc_def0, 64'h0fed_cba9_8765_4321}, 16'hf0f0,
                    {64'h5a5a_0000_1111_2222, 64'ha5a5_0000_3333_4444},
                    {64'h1234_5678_9abc_def0, 64'h0fed_cba9_8765_4321},
                    {64'h5a5a_0000_1111_2222, 64'ha5a5_0000_3333_4444}};
        rows[5] = '{1'b1, 40'h00_9000_0080, 5'h00, DMEM_LOAD, 3'd3,
                    128'h0, 16'h0000,
                    {64'h7777_0000_5555_6666, 64'h8888_0000_9999_aaaa}, 128'h0,
                    {64'h7777_0000_5555_6666, 64'h8888_0000_9999_aaaa}};
    endtask

    initial begin
        int errs0;
        rst_n_i          = 1'b0;
        ptw_req_valid_i  = 1'b0;
        ptw_req_addr_i   = '0;
        ptw_req_cmd_i    = '0;
        ptw_req_typ_i    = '0;
        ptw_req_data_i   = '0;
        core_req_valid_i = 1'b0;
        core_req_addr_i  = '0;
        core_req_op_i    = DMEM_LOAD;
        core_req_size_i  = '0;
        core_req_wdata_i = '0;
        core_req_be_i    = '0;
        grant_valid_i    = 1'b0;
        grant_beat_i     = '0;
        l2_hit_i         = 1'b0;
        load_table();
        repeat (3) @(posedge clk_i);
        rst_n_i <= 1'b1;
        @(posedge clk_i);
        errs0 = err_cnt;
        @(posedge clk_i);
        check_val("ptw_req_ready_o", ptw_req_ready_o, 1'b0);
        check_val("core_req_ready_o", core_req_ready_o, 1'b0);
        check_val("dmem_req_valid_o", dmem_req_valid_o, 1'b0);
        check_val("ptw_rsp_valid_o", ptw_rsp_valid_o, 1'b0);
        check_val("core_rsp_valid_o", core_rsp_valid_o, 1'b0);
        check_val("refill_count_o", refill_count_o, 0);
        check_val("refill_l2_hit_count_o", refill_l2_hit_count_o, 0);
        report_test("after reset", errs0);
        run_row("walker load, lane 0", 0);
        run_row("walker load, lane 1", 1);
        run_row("walker AMO-OR, lane 1", 2);
        run_row("walker AMO-OR, lane 0", 3);
        run_row("core store", 4);
        run_row("core load", 5);
        dual_test();
        refill_test();
        $display("Summary: %0d tests, %0d failed, %0d check errors",
                 tests_run, tests_failed, err_cnt);
        if (err_cnt == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+verilog
verilog/tile_mem_pkg.sv
verilog/dmem_req_if.sv
verilog/ptw_req_packer.sv
verilog/ptw_rdata_picker.sv
verilog/dmem_port_ctrl.sv
verilog/refill_event_counter.sv
verilog/tile_mem_glue.sv
sim/tb_tile_mem_glue.sv
